// File: dv/lcd_tb.sv
`timescale 1ns/10ps

module lcd_tb;

	localparam int t          = 2;    // cycles per us, keeps the run short
	localparam int hs_limit   = 500;  // longest stall is one command slot
	localparam int poll_limit = 1000; // status reads per wait

	logic                clk;
	logic                reset;
	logic                awvalid;
	logic                awready;
	lcd_pkg::axil_addr_t awaddr;
	logic                wvalid;
	logic                wready;
	lcd_pkg::axil_data_t wdata;
	logic                bvalid;
	logic                bready;
	lcd_pkg::axil_resp_t bresp;
	logic                arvalid;
	logic                arready;
	lcd_pkg::axil_addr_t araddr;
	logic                rvalid;
	logic                rready;
	lcd_pkg::axil_data_t rdata;
	lcd_pkg::axil_resp_t rresp;
	logic                e;
	logic                rs;
	logic                rw;
	lcd_pkg::lcd_byte_t  lcd_data;
	lcd_pkg::lcd_byte_t  lcd_data_in;

	logic [31:0]        lfsr;
	lcd_pkg::lcd_byte_t panel_byte; // shown by the panel on the next read
	logic [9:0]         seen_q [$]; // {rs, rw, data} at each e rise
	int                 rise_q [$]; // cycle of each e rise
	int                 width_q [$]; // e high time in cycles
	logic [9:0]         exp_q [$];
	int                 base; // log index where the current test starts

	lcd_ctrl_top #(.cycles_per_us(t), .queue_depth(4)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// pin monitor and panel model, sampled between clock edges
	initial begin
		int   cyc;
		int   rise_cyc;
		logic e_prev;
		cyc         = 0;
		rise_cyc    = 0;
		e_prev      = 1'b0;
		lcd_data_in = '0;
		forever begin
			@(negedge clk);
			cyc = cyc + 1;
			if (e && !e_prev) begin
				seen_q.push_back({rs, rw, lcd_data});
				rise_q.push_back(cyc);
				rise_cyc = cyc;
			end
			if (!e && e_prev) width_q.push_back(cyc - rise_cyc);
			// panel answers a read only while e is high
			lcd_data_in = (e && rw) ? panel_byte : ~panel_byte;
			e_prev = e;
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] seen, input logic [31:0] exp);
		if (seen !== exp) begin
			abort_run($sformatf("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
				$time, name, seen, exp));
		end
	endtask

	// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// bytes of the four init writes, built from the config bits
	function automatic lcd_pkg::lcd_byte_t init_byte(input int idx, input lcd_pkg::lcd_config_t c);
		case (idx)
			0:       return {4'b0011, c[6], c[5], 2'b00}; // function set
			1:       return {5'b00001, c[4], c[3], c[2]}; // display on/off
			2:       return 8'b0000_0001; // clear
			default: return {6'b000001, c[1], c[0]}; // entry mode
		endcase
	endfunction

	task automatic axil_write(input lcd_pkg::axil_addr_t addr, input lcd_pkg::axil_data_t data,
			output lcd_pkg::axil_resp_t resp);
		int n;
		@(negedge clk);
		awvalid = 1'b1;
		awaddr  = addr;
		wvalid  = 1'b1;
		wdata   = data;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > hs_limit) begin
				abort_run("Timeout: write address and data never accepted");
			end
		end while (!(awready && wready));
		@(negedge clk); // handshake edge has passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		while (!bvalid) begin
			@(negedge clk);
			n++;
			if (n > hs_limit) abort_run("Timeout: no write response");
		end
		resp = bresp;
	endtask

	task automatic axil_read(input lcd_pkg::axil_addr_t addr, output lcd_pkg::axil_data_t data,
			output lcd_pkg::axil_resp_t resp);
		int n;
		@(negedge clk);
		arvalid = 1'b1;
		araddr  = addr;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > hs_limit) abort_run("Timeout: read address never accepted");
		end while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid) begin
			@(negedge clk);
			n++;
			if (n > hs_limit) abort_run("Timeout: no read data");
		end
		data = rdata;
		resp = rresp;
	endtask

	task automatic read_status(output lcd_pkg::axil_data_t st);
		lcd_pkg::axil_resp_t resp;
		axil_read(lcd_pkg::reg_status, st, resp);
		check_value("rresp", 32'(resp), 32'(lcd_pkg::resp_okay));
	endtask

	task automatic wait_idle(output lcd_pkg::axil_data_t st);
		int n;
		n = 0;
		do begin
			read_status(st);
			n++;
			if (n > poll_limit) abort_run("Timeout: sequencer stayed busy");
		end while (st[lcd_pkg::st_busy]);
	endtask

	task automatic start_test();
		base = seen_q.size();
		exp_q.delete();
	endtask

	task automatic send_cmd(input logic [9:0] cmd);
		lcd_pkg::axil_resp_t resp;
		axil_write(lcd_pkg::reg_cmd, {22'b0, cmd}, resp);
		check_value("bresp", 32'(resp), 32'(lcd_pkg::resp_okay));
		exp_q.push_back(cmd);
	endtask

	// pins of each command, its 13 us pulse and the 50 us slot pitch
	task automatic check_pulses();
		check_value("e pulse count", seen_q.size() - base, exp_q.size());
		for (int i = 0; i < exp_q.size(); i++) begin
			check_value("{rs, rw, lcd_data}", 32'(seen_q[base + i]), 32'(exp_q[i]));
			check_value("e high cycles", width_q[base + i], 13 * t);
			if (i > 0) begin
				check_value("e rise spacing", rise_q[base + i] - rise_q[base + i - 1], 50 * t);
			end
		end
	endtask

	task automatic test_init();
		logic [31:0]          r;
		lcd_pkg::lcd_config_t c;
		lcd_pkg::axil_resp_t  resp;
		lcd_pkg::axil_data_t  st;
		int                   n;
		start_test();
		r = rand_bits(7);
		c = r[6:0];
		axil_write(lcd_pkg::reg_config, {24'b0, 1'b1, c}, resp); // early, before power up ends
		check_value("bresp", 32'(resp), 32'(lcd_pkg::resp_okay));
		n = 0;
		do begin
			read_status(st);
			n++;
			if (n > poll_limit) abort_run("Timeout: init_done never set");
			if (!st[lcd_pkg::st_init_done]) begin
				check_value("status busy", 32'(st[lcd_pkg::st_busy]), 1);
			end
		end while (!st[lcd_pkg::st_init_done]);
		check_value("init e pulse count", seen_q.size() - base, 4);
		for (int i = 0; i < 4; i++) begin
			// rs and rw stay low during init
			check_value("init {rs, rw, lcd_data}", 32'(seen_q[base + i]), {24'b0, init_byte(i, c)});
			check_value("init e high cycles", width_q[base + i], 10 * t);
		end
	endtask

	task automatic test_cmd_order();
		logic [31:0]         r;
		lcd_pkg::axil_data_t st;
		start_test();
		for (int i = 0; i < 3; i++) begin
			r = rand_bits(8);
			send_cmd({2'b10, r[7:0]}); // data write
		end
		wait_idle(st);
		check_pulses();
	endtask

	task automatic test_back_pressure();
		logic [31:0]         r;
		lcd_pkg::axil_data_t st;
		start_test();
		for (int i = 0; i < 6; i++) begin
			r = rand_bits(9);
			send_cmd({r[8], 1'b0, r[7:0]});
			if (i == 4) begin // one on the bus, four waiting
				read_status(st);
				check_value("status queue_full", 32'(st[lcd_pkg::st_queue_full]), 1);
			end
		end
		wait_idle(st);
		check_value("status queue_empty", 32'(st[lcd_pkg::st_queue_empty]), 1);
		check_pulses();
	endtask

	task automatic test_lcd_read();
		logic [31:0]         r;
		lcd_pkg::axil_data_t st;
		lcd_pkg::axil_resp_t resp;
		start_test();
		r = rand_bits(17);
		panel_byte = r[16:9];
		send_cmd({r[8], 1'b1, r[7:0]});
		wait_idle(st);
		check_pulses();
		axil_read(lcd_pkg::reg_read_data, st, resp);
		check_value("rresp", 32'(resp), 32'(lcd_pkg::resp_okay));
		check_value("read_data", st, {24'b0, panel_byte});
	endtask

	task automatic test_reg_errors();
		lcd_pkg::axil_data_t st;
		lcd_pkg::axil_data_t idle_st;
		lcd_pkg::axil_resp_t resp;
		axil_write(lcd_pkg::reg_status, 32'h1, resp); // read only offset
		check_value("bresp", 32'(resp), 32'(lcd_pkg::resp_slverr));
		axil_read(4'h6, st, resp); // nothing mapped here
		check_value("rresp", 32'(resp), 32'(lcd_pkg::resp_slverr));
		idle_st = '0;
		idle_st[lcd_pkg::st_init_done]   = 1'b1;
		idle_st[lcd_pkg::st_queue_empty] = 1'b1;
		read_status(st);
		check_value("status", st, idle_st);
	endtask

	initial begin
		reset      = 1'b1;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		bready     = 1'b1;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b1;
		lfsr       = 32'h7a73_3a0d;
		panel_byte = '0;
		base       = 0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		test_init();
		test_cmd_order();
		test_back_pressure();
		test_lcd_read();
		test_reg_errors();
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: dv/lcd_tb_checker.sv
`timescale 1ns/10ps

module lcd_tb_checker (
	input logic                clk,
	input logic                reset,
	input lcd_pkg::seq_state_t state,
	input logic                cmd_valid,
	input logic                busy,
	input logic                e,
	input logic                rs,
	input logic                rw,
	input lcd_pkg::lcd_byte_t  lcd_data
);

	// a queued command leaves idle at once
	cmd_taken_from_idle: assert property (@(posedge clk) disable iff (reset)
		(state == lcd_pkg::idle && cmd_valid) |=> busy)
		else $error("command waiting in idle was not taken");

	// panel latches on the falling edge so the bus holds for the whole pulse
	pins_stable_in_pulse: assert property (@(posedge clk) disable iff (reset)
		(e && $past(e)) |-> $stable({rs, rw, lcd_data}))
		else $error("rs, rw or lcd_data changed while e high");

	no_pulse_in_idle: assert property (@(posedge clk) disable iff (reset)
		(state == lcd_pkg::idle) |-> !e)
		else $error("e high while idle");

endmodule

bind lcd_bus_sequencer lcd_tb_checker u_checker (
	.clk, .reset, .state, .cmd_valid, .busy, .e, .rs, .rw, .lcd_data
);

// File: logic/lcd_axil_decode.sv
`timescale 1ns/10ps

module lcd_axil_decode (
	input  logic                 clk,
	input  logic                 reset,
	// write address and data
	input  logic                 awvalid,
	output logic                 awready,
	input  lcd_pkg::axil_addr_t  awaddr,
	input  logic                 wvalid,
	output logic                 wready,
	input  lcd_pkg::axil_data_t  wdata,
	// write response
	output logic                 bvalid,
	input  logic                 bready,
	output lcd_pkg::axil_resp_t  bresp,
	// read address and data
	input  logic                 arvalid,
	output logic                 arready,
	input  lcd_pkg::axil_addr_t  araddr,
	output logic                 rvalid,
	input  logic                 rready,
	output lcd_pkg::axil_data_t  rdata,
	output lcd_pkg::axil_resp_t  rresp,
	// status inputs
	input  logic                 queue_full,
	input  logic                 queue_empty,
	input  logic                 busy,
	input  logic                 init_done,
	input  lcd_pkg::lcd_byte_t   read_data,
	// requests to queue and sequencer
	output logic                 push,
	output lcd_pkg::lcd_cmd_t    push_cmd,
	output lcd_pkg::lcd_config_t cfg,
	output logic                 init_start
);

	logic                cmd_wr;
	logic                cfg_wr;
	logic                wr_go;
	logic                rd_go;
	lcd_pkg::axil_data_t status_word;

	assign cmd_wr = (awaddr == lcd_pkg::reg_cmd);
	assign cfg_wr = (awaddr == lcd_pkg::reg_config);

	// a cmd write waits here until the queue has room
	assign wr_go = awvalid && wvalid && !awready && !bvalid && !(cmd_wr && queue_full);
	assign rd_go = arvalid && !arready && !rvalid;

	always_comb begin
		status_word = '0;
		status_word[lcd_pkg::st_busy]        = busy;
		status_word[lcd_pkg::st_init_done]   = init_done;
		status_word[lcd_pkg::st_queue_full]  = queue_full;
		status_word[lcd_pkg::st_queue_empty] = queue_empty;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			awready    <= 1'b0;
			wready     <= 1'b0;
			bvalid     <= 1'b0;
			push       <= 1'b0;
			init_start <= 1'b0;
			cfg        <= '0;
		end else begin
			awready    <= wr_go; // single cycle pulse
			wready     <= wr_go;
			push       <= 1'b0;
			init_start <= 1'b0;
			if (awready) begin // handshake cycle
				bvalid <= 1'b1;
				push   <= cmd_wr;
				if (cfg_wr) begin
					cfg        <= wdata[6:0];
					init_start <= wdata[7];
				end
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (awready) begin
			push_cmd <= lcd_pkg::lcd_cmd_t'(wdata[9:0]);
			bresp    <= (cmd_wr || cfg_wr) ? lcd_pkg::resp_okay : lcd_pkg::resp_slverr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= rd_go;
			if (arready) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// read data mux, reg_cmd reads back as an error
	always_ff @(posedge clk) begin
		if (arready) begin
			rresp <= lcd_pkg::resp_okay;
			case (araddr)
				lcd_pkg::reg_config:    rdata <= lcd_pkg::axil_data_t'(cfg);
				lcd_pkg::reg_status:    rdata <= status_word;
				lcd_pkg::reg_read_data: rdata <= lcd_pkg::axil_data_t'(read_data);
				default: begin
					rdata <= '0;
					rresp <= lcd_pkg::resp_slverr;
				end
			endcase
		end
	end

endmodule

// File: logic/lcd_bus_sequencer.sv
`timescale 1ns/10ps

module lcd_bus_sequencer #(
	parameter int cycles_per_us = 45
) (
	input  logic                 clk,
	input  logic                 reset,
	input  lcd_pkg::lcd_config_t cfg,
	input  logic                 init_start,
	input  logic                 cmd_valid,
	input  lcd_pkg::lcd_cmd_t    cmd_out,
	output logic                 cmd_ready,
	output logic                 e,
	output logic                 rs,
	output logic                 rw,
	output lcd_pkg::lcd_byte_t   lcd_data,
	output logic                 busy,
	output logic                 init_done,
	output logic                 read_strobe
);

	localparam int t            = cycles_per_us;
	localparam int power_cycles = 500 * t;
	localparam int cnt_w        = $clog2(power_cycles + 1);

	typedef logic [cnt_w-1:0] cnt_t;

	// init phase boundaries, e high 10 us then the wait of each write
	localparam cnt_t fs_end       = cnt_t'(10 * t);
	localparam cnt_t dc_start     = cnt_t'(60 * t);
	localparam cnt_t dc_end       = cnt_t'(70 * t);
	localparam cnt_t clr_start    = cnt_t'(120 * t);
	localparam cnt_t clr_end      = cnt_t'(130 * t);
	localparam cnt_t em_start     = cnt_t'(330 * t);
	localparam cnt_t em_end       = cnt_t'(340 * t);
	localparam cnt_t init_last    = cnt_t'(440 * t - 1);
	localparam cnt_t power_last   = cnt_t'(power_cycles - 1);
	// command slot
	localparam cnt_t pulse_start  = cnt_t'(t);
	localparam cnt_t pulse_end    = cnt_t'(14 * t);
	localparam cnt_t slot_last    = cnt_t'(50 * t - 1);

	lcd_pkg::seq_state_t state;
	cnt_t                cnt;
	logic                init_pending;
	logic                init_req;
	logic                take;
	lcd_pkg::lcd_cmd_t   cur_cmd;
	logic                e_d;
	logic                rs_d;
	logic                rw_d;
	lcd_pkg::lcd_byte_t  data_d;

	assign init_req  = init_pending || init_start;
	// back to back commands chain from the last slot cycle
	assign cmd_ready = (state == lcd_pkg::idle) ||
	                   (state == lcd_pkg::cmd_slot && cnt == slot_last);
	assign take      = cmd_valid && cmd_ready;
	assign busy      = (state != lcd_pkg::idle);
	assign init_done = (state == lcd_pkg::idle) || (state == lcd_pkg::cmd_slot);
	// last e high cycle of a read, pins fall at the next edge
	assign read_strobe = e && !e_d && rw;

	// pin values for the current cycle, registered below
	always_comb begin
		e_d    = 1'b0;
		rs_d   = 1'b0;
		rw_d   = 1'b0;
		data_d = '0;
		case (state)
			lcd_pkg::init_run: begin
				if (cnt < dc_start) begin // function set
					data_d = {4'b0011, cfg[6], cfg[5], 2'b00};
					e_d    = (cnt < fs_end);
				end else if (cnt < clr_start) begin // display on/off
					data_d = {5'b00001, cfg[4], cfg[3], cfg[2]};
					e_d    = (cnt < dc_end);
				end else if (cnt < em_start) begin // clear
					data_d = 8'b0000_0001;
					e_d    = (cnt < clr_end);
				end else begin // entry mode
					data_d = {6'b000001, cfg[1], cfg[0]};
					e_d    = (cnt < em_end);
				end
			end
			lcd_pkg::cmd_slot: begin
				rs_d   = cur_cmd.rs;
				rw_d   = cur_cmd.rw;
				data_d = cur_cmd.data;
				e_d    = (cnt >= pulse_start) && (cnt < pulse_end);
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= lcd_pkg::power_wait;
			cnt          <= '0;
			init_pending <= 1'b0;
			e            <= 1'b0;
			rs           <= 1'b0;
			rw           <= 1'b0;
			lcd_data     <= '0;
		end else begin
			e        <= e_d;
			rs       <= rs_d;
			rw       <= rw_d;
			lcd_data <= data_d;
			if (init_start) init_pending <= 1'b1; // kept if it comes early
			case (state)
				lcd_pkg::power_wait: begin
					cnt <= cnt + 1'b1;
					if (cnt == power_last) begin
						cnt   <= '0;
						state <= init_req ? lcd_pkg::init_run : lcd_pkg::wait_init;
					end
				end
				lcd_pkg::wait_init: begin
					if (init_req) state <= lcd_pkg::init_run;
				end
				lcd_pkg::init_run: begin
					cnt <= cnt + 1'b1;
					if (cnt == init_last) begin
						cnt   <= '0;
						state <= lcd_pkg::idle;
					end
				end
				lcd_pkg::idle: begin
					cnt <= '0;
					if (take) state <= lcd_pkg::cmd_slot;
				end
				lcd_pkg::cmd_slot: begin
					cnt <= cnt + 1'b1;
					if (cnt == slot_last) begin
						cnt <= '0;
						if (!take) state <= lcd_pkg::idle;
					end
				end
				default: state <= lcd_pkg::power_wait;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) cur_cmd <= cmd_out;
	end

endmodule

// File: logic/lcd_cmd_queue.sv
`timescale 1ns/10ps

module lcd_cmd_queue #(
	parameter int depth = 4 // power of two
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              push,
	input  lcd_pkg::lcd_cmd_t push_cmd,
	input  logic              cmd_ready,
	output logic              cmd_valid,
	output lcd_pkg::lcd_cmd_t cmd_out,
	output logic              queue_full,
	output logic              queue_empty
);

	localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_w = $clog2(depth + 1);

	typedef logic [ptr_w-1:0]   ptr_t;
	typedef logic [count_w-1:0] count_t;

	lcd_pkg::lcd_cmd_t mem [depth];
	ptr_t              wr_ptr;
	ptr_t              rd_ptr;
	count_t            count;
	logic              do_push;
	logic              do_pop;

	assign queue_full  = (count == count_t'(depth));
	assign queue_empty = (count == '0);
	assign cmd_valid   = !queue_empty;
	assign cmd_out     = mem[rd_ptr]; // head entry

	assign do_push = push && !queue_full;
	assign do_pop  = cmd_valid && cmd_ready;

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= push_cmd;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/lcd_ctrl_top.sv
`timescale 1ns/10ps

module lcd_ctrl_top #(
	parameter int cycles_per_us = 45,
	parameter int queue_depth   = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                awvalid,
	output logic                awready,
	input  lcd_pkg::axil_addr_t awaddr,
	input  logic                wvalid,
	output logic                wready,
	input  lcd_pkg::axil_data_t wdata,
	output logic                bvalid,
	input  logic                bready,
	output lcd_pkg::axil_resp_t bresp,
	input  logic                arvalid,
	output logic                arready,
	input  lcd_pkg::axil_addr_t araddr,
	output logic                rvalid,
	input  logic                rready,
	output lcd_pkg::axil_data_t rdata,
	output lcd_pkg::axil_resp_t rresp,
	// panel pins
	output logic                e,
	output logic                rs,
	output logic                rw,
	output lcd_pkg::lcd_byte_t  lcd_data,
	input  lcd_pkg::lcd_byte_t  lcd_data_in
);

	logic                 push;
	lcd_pkg::lcd_cmd_t    push_cmd;
	lcd_pkg::lcd_config_t cfg;
	logic                 init_start;
	logic                 cmd_valid;
	logic                 cmd_ready;
	lcd_pkg::lcd_cmd_t    cmd_out;
	logic                 queue_full;
	logic                 queue_empty;
	logic                 busy;
	logic                 init_done;
	logic                 read_strobe;
	lcd_pkg::lcd_byte_t   read_data;

	lcd_axil_decode u_decode (
		.clk, .reset,
		.awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
		.queue_full, .queue_empty, .busy, .init_done, .read_data,
		.push, .push_cmd, .cfg, .init_start
	);

	lcd_cmd_queue #(.depth(queue_depth)) u_queue (
		.clk, .reset, .push, .push_cmd, .cmd_ready,
		.cmd_valid, .cmd_out, .queue_full, .queue_empty
	);

	lcd_bus_sequencer #(.cycles_per_us(cycles_per_us)) u_seq (
		.clk, .reset, .cfg, .init_start, .cmd_valid, .cmd_out,
		.cmd_ready, .e, .rs, .rw, .lcd_data, .busy, .init_done, .read_strobe
	);

	lcd_read_capture u_capture (
		.clk, .reset, .read_strobe, .lcd_data_in, .read_data
	);

endmodule

// File: logic/lcd_pkg.sv
package lcd_pkg;

	// one byte on the panel data bus
	typedef logic [7:0] lcd_byte_t;

	// {display_lines, character_font, display_on_off, cursor, blink, inc_dec, shift}
	typedef logic [6:0] lcd_config_t;

	// raw bus command, rs in the top bit
	typedef struct packed {
		logic      rs;
		logic      rw;
		lcd_byte_t data;
	} lcd_cmd_t;

	typedef logic [3:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0]  axil_resp_t;

	// register map
	localparam axil_addr_t reg_config    = 4'h0; // cfg in 6:0, bit 7 starts init
	localparam axil_addr_t reg_cmd       = 4'h4; // write only, pushes a command
	localparam axil_addr_t reg_status    = 4'h8; // read only
	localparam axil_addr_t reg_read_data = 4'hc; // read only, last captured byte

	localparam axil_resp_t resp_okay   = 2'b00;
	localparam axil_resp_t resp_slverr = 2'b10;

	// status word bit positions
	localparam int st_busy        = 0;
	localparam int st_init_done   = 1;
	localparam int st_queue_full  = 2;
	localparam int st_queue_empty = 3;

	typedef enum logic [2:0] {
		power_wait, // 500 us after reset
		wait_init,  // power up done, no init request yet
		init_run,   // the four init writes and their waits
		idle,
		cmd_slot    // one 50 us command slot
	} seq_state_t;

endpackage

// File: logic/lcd_read_capture.sv
`timescale 1ns/10ps

module lcd_read_capture (
	input  logic               clk,
	input  logic               reset,
	input  logic               read_strobe,
	input  lcd_pkg::lcd_byte_t lcd_data_in,
	output lcd_pkg::lcd_byte_t read_data
);

	// panel drives the bus while e is high, sample as e drops
	always_ff @(posedge clk) begin
		if (reset) begin
			read_data <= '0;
		end else if (read_strobe) begin
			read_data <= lcd_data_in;
		end
	end

endmodule

// File: project.f
logic/lcd_pkg.sv
logic/lcd_axil_decode.sv
logic/lcd_cmd_queue.sv
logic/lcd_bus_sequencer.sv
logic/lcd_read_capture.sv
logic/lcd_ctrl_top.sv
dv/lcd_tb_checker.sv
dv/lcd_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LCD controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module lcd_tb \
	-Mdir obj_dir -o lcd_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/lcd_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "run ended with exit status $status"
	exit $status
fi
exit 0
